// ==== clock_gate.sv ====
//////////////////////////////////////////////////////////////////////
// Generic latch-based clock gate with scan override
//////////////////////////////////////////////////////////////////////

module clock_gate (
  input  logic clk_i,
  input  logic en_i,
  input  logic scan_cg_en_i,
  output logic clk_o
);

  logic en_latch;

  // Transparent while the clock is low, so enable changes
  // never reach the output during the high phase
  always_latch begin
    if (!clk_i) begin
      en_latch <= en_i | scan_cg_en_i;
    end
  end

  assign clk_o = clk_i & en_latch;

endmodule

// ==== core_ctrl.sv ====
//////////////////////////////////////////////////////////////////////
// Core controller, decodes and sequences NOP, LOAD and WFI
// Produces accept, retire and the wake request for the sleep unit
//////////////////////////////////////////////////////////////////////

module core_ctrl (
  input  logic                          clk_i,
  input  logic                          rst_n,
  // From fetch
  input  logic                          instr_valid_i,
  input  logic [pwr_pkg::INSTR_W-1:0]   instr_i,
  // From the load-store unit
  input  logic                          lsu_done_i,
  input  logic                          irq_i,
  // To fetch
  output logic                          instr_accept_o,
  output logic                          wfi_enter_o,
  output logic                          resume_o,
  // To the load-store unit
  output logic                          lsu_start_o,
  output logic [pwr_pkg::OPERAND_W-1:0] lsu_len_o,
  // To the sleep unit
  output logic                          wake_o,
  output logic                          ctrl_busy_o,
  // Retire report
  output logic                          retire_o,
  output pwr_pkg::opcode_e              retire_op_o
);

  pwr_pkg::ctrl_state_e state_q;
  pwr_pkg::ctrl_state_e state_d;
  pwr_pkg::opcode_e     opcode;

  // Field split
  assign opcode    = pwr_pkg::opcode_e'(instr_i[pwr_pkg::OPCODE_MSB:pwr_pkg::OPCODE_LSB]);
  assign lsu_len_o = instr_i[pwr_pkg::OPERAND_W-1:0];

  //////////////////////////////////////////////////////////////////////
  // Decode FSM
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d        = state_q;
    instr_accept_o = 1'b0;
    lsu_start_o    = 1'b0;
    wfi_enter_o    = 1'b0;
    resume_o       = 1'b0;
    wake_o         = 1'b0;
    case (state_q)
      pwr_pkg::CTRL_RUN: begin
        if (instr_valid_i) begin
          case (opcode)
            pwr_pkg::OP_LOAD: begin
              // Hold the word until the access completes
              lsu_start_o = 1'b1;
              state_d     = pwr_pkg::CTRL_LOAD_WAIT;
            end
            pwr_pkg::OP_WFI: begin
              instr_accept_o = 1'b1;
              wfi_enter_o    = 1'b1;
              state_d        = pwr_pkg::CTRL_WFI;
            end
            // NOP and reserved retire at once
            default: begin
              instr_accept_o = 1'b1;
            end
          endcase
        end
      end
      pwr_pkg::CTRL_LOAD_WAIT: begin
        if (lsu_done_i) begin
          instr_accept_o = 1'b1;
          state_d        = pwr_pkg::CTRL_RUN;
        end
      end
      pwr_pkg::CTRL_WFI: begin
        // Interrupt level opens the clock, first edge restarts fetch
        wake_o   = irq_i;
        resume_o = irq_i;
        if (irq_i) begin
          state_d = pwr_pkg::CTRL_RUN;
        end
      end
      default: begin
        state_d = pwr_pkg::CTRL_RUN;
      end
    endcase
  end

  // Only a WFI lets the clock stop
  assign ctrl_busy_o = (state_q != pwr_pkg::CTRL_WFI);

  always_ff @(posedge clk_i, negedge rst_n) begin
    if (!rst_n) begin
      state_q  <= pwr_pkg::CTRL_RUN;
      retire_o <= 1'b0;
    end else begin
      state_q  <= state_d;
      // One gated cycle per retired instruction
      retire_o <= instr_accept_o;
    end
  end

  // Opcode of the retiring word, valid with retire_o
  always_ff @(posedge clk_i) begin
    if (instr_accept_o) begin
      retire_op_o <= opcode;
    end
  end

endmodule

// ==== core_top.sv ====
//////////////////////////////////////////////////////////////////////
// Top level of the clock-gated core shell
// Sleep unit on the free clock, everything else on the gated clock
//////////////////////////////////////////////////////////////////////

module core_top (
  input  logic                        clk_ungated_i,
  input  logic                        rst_n,
  input  logic                        scan_cg_en_i,
  input  logic                        fetch_enable_i,
  input  logic                        irq_i,
  // Instruction port
  output logic                        instr_req_o,
  output logic [pwr_pkg::ADDR_W-1:0]  instr_addr_o,
  input  logic [pwr_pkg::INSTR_W-1:0] instr_rdata_i,
  // Status
  output logic                        retire_o,
  output pwr_pkg::opcode_e            retire_op_o,
  output logic                        core_sleep_o,
  output logic                        clk_gated_o
);

  logic                          clk_gated;
  logic                          fetch_enable;
  // Busy and wake
  logic                          if_busy;
  logic                          ctrl_busy;
  logic                          lsu_busy;
  logic                          wake;
  // Fetch to controller
  logic                          instr_valid;
  logic [pwr_pkg::INSTR_W-1:0]   instr;
  logic                          instr_accept;
  logic                          wfi_enter;
  logic                          resume;
  // Controller to load-store unit
  logic                          lsu_start;
  logic [pwr_pkg::OPERAND_W-1:0] lsu_len;
  logic                          lsu_done;

  sleep_unit u_sleep_unit (
    .clk_ungated_i     (clk_ungated_i),
    .rst_n             (rst_n),
    .scan_cg_en_i      (scan_cg_en_i),
    .fetch_enable_i    (fetch_enable_i),
    .fetch_enable_o    (fetch_enable),
    .if_busy_i         (if_busy),
    .ctrl_busy_i       (ctrl_busy),
    .lsu_busy_i        (lsu_busy),
    .wake_from_sleep_i (wake),
    .clk_gated_o       (clk_gated),
    .core_sleep_o      (core_sleep_o)
  );

  fetch_unit u_fetch_unit (
    .clk_i          (clk_gated),
    .rst_n          (rst_n),
    .fetch_enable_i (fetch_enable),
    .instr_accept_i (instr_accept),
    .wfi_enter_i    (wfi_enter),
    .resume_i       (resume),
    .instr_rdata_i  (instr_rdata_i),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_valid_o  (instr_valid),
    .instr_o        (instr),
    .if_busy_o      (if_busy)
  );

  core_ctrl u_core_ctrl (
    .clk_i          (clk_gated),
    .rst_n          (rst_n),
    .instr_valid_i  (instr_valid),
    .instr_i        (instr),
    .lsu_done_i     (lsu_done),
    .irq_i          (irq_i),
    .instr_accept_o (instr_accept),
    .wfi_enter_o    (wfi_enter),
    .resume_o       (resume),
    .lsu_start_o    (lsu_start),
    .lsu_len_o      (lsu_len),
    .wake_o         (wake),
    .ctrl_busy_o    (ctrl_busy),
    .retire_o       (retire_o),
    .retire_op_o    (retire_op_o)
  );

  lsu u_lsu (
    .clk_i   (clk_gated),
    .rst_n   (rst_n),
    .start_i (lsu_start),
    .len_i   (lsu_len),
    .busy_o  (lsu_busy),
    .done_o  (lsu_done)
  );

  // Exported for observation
  assign clk_gated_o = clk_gated;

endmodule

// ==== fetch_unit.sv ====
//////////////////////////////////////////////////////////////////////
// Fetch unit, one instruction word per gated cycle
// Address advances on accept, fetch stops on WFI until resume
//////////////////////////////////////////////////////////////////////

module fetch_unit (
  input  logic                        clk_i,
  input  logic                        rst_n,
  input  logic                        fetch_enable_i,
  input  logic                        instr_accept_i,
  input  logic                        wfi_enter_i,
  input  logic                        resume_i,
  input  logic [pwr_pkg::INSTR_W-1:0] instr_rdata_i,
  // Instruction port
  output logic                        instr_req_o,
  output logic [pwr_pkg::ADDR_W-1:0]  instr_addr_o,
  // To the controller
  output logic                        instr_valid_o,
  output logic [pwr_pkg::INSTR_W-1:0] instr_o,
  output logic                        if_busy_o
);

  logic [pwr_pkg::ADDR_W-1:0] addr_q;
  logic                       stopped_q;
  logic                       active;

  always_ff @(posedge clk_i, negedge rst_n) begin
    if (!rst_n) begin
      addr_q    <= '0;
      stopped_q <= 1'b0;
    end else begin
      // Next word, wraps at the end of the address space
      if (instr_accept_i) begin
        addr_q <= addr_q + 1'b1;
      end
      // WFI stops fetch, wake restarts it
      if (wfi_enter_i) begin
        stopped_q <= 1'b1;
      end else if (resume_i) begin
        stopped_q <= 1'b0;
      end
    end
  end

  assign active = fetch_enable_i & ~stopped_q;

  // Read data comes back in the same cycle
  assign instr_req_o   = active;
  assign instr_addr_o  = addr_q;
  assign instr_valid_o = active;
  assign instr_o       = instr_rdata_i;

  // Needs the clock whenever it is fetching
  assign if_busy_o = active;

endmodule

// ==== lsu.sv ====
//////////////////////////////////////////////////////////////////////
// Load-store latency model
// Busy for len cycles after start, done in the last busy cycle
//////////////////////////////////////////////////////////////////////

module lsu (
  input  logic                          clk_i,
  input  logic                          rst_n,
  input  logic                          start_i,
  input  logic [pwr_pkg::OPERAND_W-1:0] len_i,
  output logic                          busy_o,
  output logic                          done_o
);

  logic [pwr_pkg::OPERAND_W-1:0] cnt_q;

  always_ff @(posedge clk_i, negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else if (start_i) begin
      // Zero length still takes one cycle
      cnt_q <= (len_i == '0) ? pwr_pkg::OPERAND_W'(1) : len_i;
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign busy_o = (cnt_q != '0);

  // Count reaches zero at the next edge
  assign done_o = (cnt_q == pwr_pkg::OPERAND_W'(1));

  // Controller only starts an access from the run state
  a_no_start_when_busy: assert property (
    @(posedge clk_i) disable iff (!rst_n)
    start_i |-> !busy_o)
    else $error("lsu started while busy");

endmodule

// ==== pwr_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Shared types and constants of the clock-gated core shell
// Referenced by scoped names from every block and the testbench
//////////////////////////////////////////////////////////////////////

package pwr_pkg;

  //////////////////////////////////////////////////////////////////////
  // Instruction word layout
  //////////////////////////////////////////////////////////////////////

  // Full instruction word
  localparam int INSTR_W    = 8;
  // Instruction address, wraps at the top
  localparam int ADDR_W     = 8;
  // Opcode field in the upper two bits
  localparam int OPCODE_MSB = 7;
  localparam int OPCODE_LSB = 6;
  // Operand field in bits 5 to 0
  localparam int OPERAND_W  = 6;

  //////////////////////////////////////////////////////////////////////
  // Enumerations
  //////////////////////////////////////////////////////////////////////

  // Opcodes, reserved one retires like a NOP
  typedef enum logic [1:0] {
    OP_NOP  = 2'd0,
    OP_LOAD = 2'd1,
    OP_WFI  = 2'd2,
    OP_RSVD = 2'd3
  } opcode_e;

  // Controller states
  typedef enum logic [1:0] {
    CTRL_RUN       = 2'd0,
    CTRL_LOAD_WAIT = 2'd1,
    CTRL_WFI       = 2'd2
  } ctrl_state_e;

endpackage

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the core shell testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_core_top -f vlog.f

out=$(./obj_dir/Vtb_core_top)
echo "$out"

if echo "$out" | grep -qF '*** TEST PASSED ***'; then
  exit 0
fi
exit 1

// ==== sleep_unit.sv ====
//////////////////////////////////////////////////////////////////////
// Sleep unit of the core shell
// Holds the core clock off until fetch enable and while waiting on WFI
// Drives the gated clock for fetch, controller and load-store unit
//////////////////////////////////////////////////////////////////////

module sleep_unit (
  // Free running clock and reset
  input  logic clk_ungated_i,
  input  logic rst_n,
  // Forces the gate open in scan mode
  input  logic scan_cg_en_i,
  // Fetch enable in and its sticky copy out
  input  logic fetch_enable_i,
  output logic fetch_enable_o,
  // Busy flags of the sub units
  input  logic if_busy_i,
  input  logic ctrl_busy_i,
  input  logic lsu_busy_i,
  // Wake request from the controller while in WFI
  input  logic wake_from_sleep_i,
  // Gated clock and sleep status
  output logic clk_gated_o,
  output logic core_sleep_o
);

  logic fetch_enable_q;
  logic core_busy_d;
  logic core_busy_q;
  logic clock_en;

  // Any unit still needing a clock
  assign core_busy_d = if_busy_i | ctrl_busy_i | lsu_busy_i;

  always_ff @(posedge clk_ungated_i, negedge rst_n) begin
    if (!rst_n) begin
      fetch_enable_q <= 1'b0;
      core_busy_q    <= 1'b0;
    end else begin
      // Sticky flag that is never cleared once set
      if (fetch_enable_i) begin
        fetch_enable_q <= 1'b1;
      end
      core_busy_q <= core_busy_d;
    end
  end

  // Clock runs after first fetch enable while busy or waking up
  assign clock_en = fetch_enable_q & (wake_from_sleep_i | core_busy_q);

  // Sleep only once running and after a WFI drained the core
  assign core_sleep_o = fetch_enable_q & ~clock_en;

  assign fetch_enable_o = fetch_enable_q;

  // Main core clock gate
  clock_gate u_clock_gate (
    .clk_i        (clk_ungated_i),
    .en_i         (clock_en),
    .scan_cg_en_i (scan_cg_en_i),
    .clk_o        (clk_gated_o)
  );

  //////////////////////////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////////////////////////

  // Gated clock stays low before the first fetch enable unless scan forces it
  a_no_clk_before_fetch: assert property (
    @(negedge clk_ungated_i) disable iff (!rst_n)
    !fetch_enable_q && !scan_cg_en_i |-> !clk_gated_o)
    else $error("gated clock ran before fetch enable");

  // Wake only arrives from a drained core waiting in WFI
  a_wake_when_idle: assert property (
    @(posedge clk_ungated_i) disable iff (!rst_n)
    wake_from_sleep_i |-> !core_busy_d)
    else $error("wake raised while a unit is busy");

endmodule

// ==== tb_clk_gen.sv ====
//////////////////////////////////////////////////////////////////////
// Testbench clock and reset source, period 8, reset low for 10 cycles
//////////////////////////////////////////////////////////////////////

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  localparam int HALF_PERIOD  = 4;
  localparam int RESET_CYCLES = 10;

  // Free running clock
  initial begin
    clk_o = 1'b0;
    forever begin
      #(HALF_PERIOD) clk_o = ~clk_o;
    end
  end

  // Release on a falling edge, away from the active edge
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

// ==== tb_core_top.sv ====
//////////////////////////////////////////////////////////////////////
// Directed testbench of the clock-gated core shell
// ROM model feeds the instruction port, one task per test
//////////////////////////////////////////////////////////////////////

module tb_core_top;

  // Tests need about 400 cycles with reset, the rest is margin
  localparam int MAX_CYCLES = 2000;
  localparam int ROM_DEPTH  = 1 << pwr_pkg::ADDR_W;

  logic                        clk;
  logic                        rst_n;
  logic                        scan_cg_en;
  logic                        fetch_enable;
  logic                        irq;
  logic                        instr_req;
  logic [pwr_pkg::ADDR_W-1:0]  instr_addr;
  logic [pwr_pkg::INSTR_W-1:0] instr_rdata;
  logic                        retire;
  pwr_pkg::opcode_e            retire_op;
  logic                        core_sleep;
  logic                        clk_gated;

  logic [pwr_pkg::INSTR_W-1:0] rom [ROM_DEPTH];
  // Expected retires in program order, with the minimum latency of each
  pwr_pkg::opcode_e            exp_op_q[$];
  logic [pwr_pkg::ADDR_W-1:0]  exp_addr_q[$];
  int                          exp_gap_q[$];
  logic [pwr_pkg::ADDR_W-1:0]  prog_addr;
  int                          seed;
  int                          error_cnt;
  int                          test_cnt;
  int                          failed_tests;
  int                          errs;
  int                          cycle_cnt   = 0;
  int                          gated_edges = 0;

  tb_clk_gen u_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  core_top u_dut (
    .clk_ungated_i  (clk),
    .rst_n          (rst_n),
    .scan_cg_en_i   (scan_cg_en),
    .fetch_enable_i (fetch_enable),
    .irq_i          (irq),
    .instr_req_o    (instr_req),
    .instr_addr_o   (instr_addr),
    .instr_rdata_i  (instr_rdata),
    .retire_o       (retire),
    .retire_op_o    (retire_op),
    .core_sleep_o   (core_sleep),
    .clk_gated_o    (clk_gated)
  );

  // Same-cycle read data
  assign instr_rdata = rom[instr_addr];

  always @(posedge clk_gated) begin
    gated_edges <= gated_edges + 1;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Run stopped after %0d cycles, a test hung", MAX_CYCLES);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic check_op(input pwr_pkg::opcode_e got, input pwr_pkg::opcode_e exp,
                          input string what);
    if (got !== exp) begin
      error_cnt++;
      $display("FAILED t=%0t: %s is %s, expected %s", $time, what, got.name(), exp.name());
    end
  endtask

  task automatic check_addr(input logic [pwr_pkg::ADDR_W-1:0] got,
                            input logic [pwr_pkg::ADDR_W-1:0] exp, input string what);
    if (got !== exp) begin
      error_cnt++;
      $display("FAILED t=%0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      error_cnt++;
      $display("FAILED t=%0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    if (got != exp) begin
      error_cnt++;
      $display("FAILED t=%0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Program and retire helpers
  //////////////////////////////////////////////////////////////////////

  // Writes the next ROM word and queues its retire
  task automatic emit(input pwr_pkg::opcode_e op, input logic [pwr_pkg::OPERAND_W-1:0] operand);
    rom[prog_addr] = {op, operand};
    exp_op_q.push_back(op);
    exp_addr_q.push_back(prog_addr);
    // Zero length load still takes one cycle
    if (op == pwr_pkg::OP_LOAD) begin
      exp_gap_q.push_back((operand == '0) ? 1 : int'(operand));
    end else begin
      exp_gap_q.push_back(0);
    end
    prog_addr = prog_addr + 1'b1;
  endtask

  task automatic expect_next_retire(input int max_wait);
    pwr_pkg::opcode_e           op;
    logic [pwr_pkg::ADDR_W-1:0] addr;
    int                         gap;
    int                         waited;
    op   = exp_op_q.pop_front();
    addr = exp_addr_q.pop_front();
    gap  = exp_gap_q.pop_front();
    @(negedge clk);
    waited = 1;
    // Fetch holds the address until the word retires
    while (!retire && waited < gap + max_wait) begin
      check_addr(instr_addr, addr, "held fetch address");
      @(negedge clk);
      waited++;
    end
    if (!retire) begin
      error_cnt++;
      $display("No retire of %s at address %0d within %0d cycles", op.name(), addr, waited);
    end else begin
      check_op(retire_op, op, "retired opcode");
      check_addr(instr_addr, addr + 1'b1, "fetch address after retire");
      if (waited < gap) begin
        error_cnt++;
        $display("FAILED t=%0t: load at %0d retired after %0d cycles, length %0d",
                 $time, addr, waited, gap);
      end
    end
  endtask

  task automatic run_expected(input int max_wait);
    while (exp_op_q.size() > 0) begin
      expect_next_retire(max_wait);
    end
  endtask

  task automatic wait_for_sleep(input int max_wait);
    int waited;
    waited = 0;
    while (!core_sleep && waited < max_wait) begin
      @(negedge clk);
      waited++;
    end
    check_bit(core_sleep, 1'b1, "core_sleep_o after WFI");
  endtask

  // Wake pulse, one cycle is enough to leave CTRL_WFI
  task automatic raise_irq();
    irq = 1'b1;
    @(negedge clk);
    irq = 1'b0;
  endtask

  task automatic report(input string name, input int errors_before);
    test_cnt++;
    if (error_cnt == errors_before) begin
      $display("test %0d %s: ok", test_cnt, name);
    end else begin
      failed_tests++;
      $display("test %0d %s: %0d errors", test_cnt, name, error_cnt - errors_before);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_idle();
    int edges_before;
    edges_before = gated_edges;
    repeat (20) begin
      @(negedge clk);
      check_bit(instr_req, 1'b0, "instr_req_o before enable");
      check_bit(retire, 1'b0, "retire_o before enable");
      check_bit(core_sleep, 1'b0, "core_sleep_o before enable");
    end
    check_count(gated_edges - edges_before, 0, "gated edges before enable");
  endtask

  task automatic test_nop_stream();
    int waited;
    for (int i = 0; i < 8; i++) begin
      emit(pwr_pkg::OP_NOP, pwr_pkg::OPERAND_W'(i * 5 + 1));
    end
    emit(pwr_pkg::OP_WFI, '0);
    fetch_enable = 1'b1;
    waited = 0;
    while (!instr_req && waited < 5) begin
      @(negedge clk);
      waited++;
    end
    check_bit(instr_req, 1'b1, "instr_req_o within 5 cycles of enable");
    run_expected(6);
    wait_for_sleep(3);
  endtask

  task automatic test_load_latency();
    logic [31:0] rnd;
    for (int i = 0; i < 6; i++) begin
      rnd = $random(seed);
      emit(pwr_pkg::OP_LOAD, {2'b00, rnd[3:0]});
    end
    emit(pwr_pkg::OP_LOAD, '0);
    emit(pwr_pkg::OP_WFI, '0);
    raise_irq();
    run_expected(6);
    wait_for_sleep(3);
  endtask

  task automatic test_wfi_sleep();
    logic [pwr_pkg::ADDR_W-1:0] addr_hold;
    int                         edges_before;
    emit(pwr_pkg::OP_NOP, 6'h15);
    emit(pwr_pkg::OP_WFI, 6'h2a);
    raise_irq();
    run_expected(6);
    wait_for_sleep(3);
    addr_hold    = instr_addr;
    edges_before = gated_edges;
    repeat (30) begin
      @(negedge clk);
      check_addr(instr_addr, addr_hold, "fetch address while asleep");
      check_bit(core_sleep, 1'b1, "core_sleep_o while asleep");
    end
    check_count(gated_edges - edges_before, 0, "gated edges while asleep");
  endtask

  task automatic test_wake();
    emit(pwr_pkg::OP_RSVD, 6'h3f);
    emit(pwr_pkg::OP_WFI, '0);
    irq = 1'b1;
    // Mid low phase, wake acts without a clock edge
    #2;
    check_bit(core_sleep, 1'b0, "core_sleep_o with irq_i high");
    @(negedge clk);
    irq = 1'b0;
    // One cycle already spent, three more for the retire
    expect_next_retire(3);
    run_expected(6);
    wait_for_sleep(3);
  endtask

  task automatic test_scan();
    logic [pwr_pkg::ADDR_W-1:0] addr_hold;
    int                         edges_before;
    addr_hold    = instr_addr;
    edges_before = gated_edges;
    scan_cg_en   = 1'b1;
    repeat (20) begin
      @(negedge clk);
      check_bit(core_sleep, 1'b1, "core_sleep_o under scan enable");
      check_bit(retire, 1'b0, "retire_o under scan enable");
      check_addr(instr_addr, addr_hold, "fetch address under scan enable");
    end
    scan_cg_en = 1'b0;
    check_count(gated_edges - edges_before, 20, "gated edges under scan enable");
  endtask

  initial begin
    seed         = 2;
    error_cnt    = 0;
    test_cnt     = 0;
    failed_tests = 0;
    scan_cg_en   = 1'b0;
    fetch_enable = 1'b0;
    irq          = 1'b0;
    prog_addr    = '0;
    // Unused words park the core on a WFI, operand follows the address
    for (int i = 0; i < ROM_DEPTH; i++) begin
      rom[i] = {pwr_pkg::OP_WFI, pwr_pkg::OPERAND_W'(i) ^ {3{2'(i >> 6)}}};
    end
    wait (rst_n === 1'b1);
    @(negedge clk);

    errs = error_cnt;
    test_idle();
    report("idle before enable", errs);
    errs = error_cnt;
    test_nop_stream();
    report("NOP stream", errs);
    errs = error_cnt;
    test_load_latency();
    report("LOAD latency", errs);
    errs = error_cnt;
    test_wfi_sleep();
    report("WFI sleep", errs);
    errs = error_cnt;
    test_wake();
    report("wake on interrupt", errs);
    errs = error_cnt;
    test_scan();
    report("scan override", errs);

    $display("tests %0d, failed tests %0d, failed checks %0d",
             test_cnt, failed_tests, error_cnt);
    if (error_cnt == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
pwr_pkg.sv
clock_gate.sv
sleep_unit.sv
fetch_unit.sv
lsu.sv
core_ctrl.sv
core_top.sv
tb_clk_gen.sv
tb_core_top.sv
